// ==== Bender.yml ====
package:
  name: bp_frontend

sources:
  - include_dirs:
      - src
    files:
      - src/bp_addr_pkg.sv
      - src/bp_entry_pkg.sv
      - src/fetch_pc_gen.sv
      - src/branch_target_buff.sv
      - src/fetch_packet_out.sv
      - src/bp_frontend_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_clock_gen.sv
      - tests/bp_frontend_sva.sv
      - tests/bp_frontend_tb.sv

// ==== src.f ====
+incdir+src
src/bp_addr_pkg.sv
src/bp_entry_pkg.sv
src/fetch_pc_gen.sv
src/branch_target_buff.sv
src/fetch_packet_out.sv
src/bp_frontend_top.sv
tests/tb_clock_gen.sv
tests/bp_frontend_sva.sv
tests/bp_frontend_tb.sv

// ==== src/bp_addr_pkg.sv ====
`default_nettype none

`include "bp_settings.svh"

package bp_addr_pkg;

    typedef logic [`BP_ADDR_W-1:0] eip_t;   // instruction pointer
    typedef logic [`BP_ADDR_W-1:0] fip_t;   // fetch-block pointer, even or odd bank
    typedef logic [`BP_TAG_W-1:0] btb_tag_t;
    typedef logic [`BP_INDEX_W-1:0] btb_idx_t;

    // upper bits of the EIP, compared against the stored tag
    function automatic btb_tag_t eip_tag(eip_t eip);
        return eip[`BP_ADDR_W-1 -: `BP_TAG_W];
    endfunction

    // low bits select the BTB line
    function automatic btb_idx_t eip_idx(eip_t eip);
        return eip[`BP_INDEX_W-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== src/bp_entry_pkg.sv ====
`default_nettype none

package bp_entry_pkg;

    // one BTB line
    typedef struct packed {
        logic                  valid;
        bp_addr_pkg::btb_tag_t tag;
        bp_addr_pkg::eip_t     target;
        bp_addr_pkg::fip_t     fip_e;
        bp_addr_pkg::fip_t     fip_o;
    } btb_entry_t;

    // writeback update for a resolved branch
    typedef struct packed {
        logic              ld;       // one-cycle write strobe
        bp_addr_pkg::eip_t eip;      // EIP of the branch
        bp_addr_pkg::eip_t target;
        bp_addr_pkg::fip_t fip_e;
        bp_addr_pkg::fip_t fip_o;
    } btb_update_t;

    // combinational read result
    typedef struct packed {
        logic              hit;
        bp_addr_pkg::eip_t target;
        bp_addr_pkg::fip_t fip_e;
        bp_addr_pkg::fip_t fip_o;
    } btb_lookup_t;

    // redirect from a later stage
    typedef struct packed {
        logic              valid;
        bp_addr_pkg::eip_t eip;
    } redirect_t;

    typedef struct packed {
        logic              valid;
        bp_addr_pkg::eip_t eip;
        logic              hit;      // predicted taken
        bp_addr_pkg::eip_t target;
        bp_addr_pkg::fip_t fip_e;
        bp_addr_pkg::fip_t fip_o;
    } fetch_packet_t;

    typedef enum logic {
        PCG_BOOT,
        PCG_FETCH
    } pcg_state_t;

endpackage

`default_nettype wire

// ==== src/bp_frontend_top.sv ====
`default_nettype none

module bp_frontend_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,      // level, holds the fetch EIP
    input  logic                        flush,      // one-cycle pulse
    input  bp_entry_pkg::redirect_t     redirect,
    input  bp_entry_pkg::btb_update_t   update,
    output bp_entry_pkg::fetch_packet_t fetch
);

    bp_addr_pkg::eip_t         fetch_eip;
    logic                      issue;
    bp_entry_pkg::btb_lookup_t lookup;

    // input side, next EIP selection
    fetch_pc_gen u_pc_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .redirect  (redirect),
        .lookup    (lookup),
        .fetch_eip (fetch_eip),
        .issue     (issue)
    );

    // BTB, read with the current fetch EIP
    branch_target_buff u_btb (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_eip (fetch_eip),
        .update    (update),
        .flush     (flush),
        .lookup    (lookup)
    );

    // registered packet toward the fetch stage
    fetch_packet_out u_pkt_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .fetch_eip (fetch_eip),
        .lookup    (lookup),
        .fetch     (fetch)
    );

endmodule

`default_nettype wire

// ==== src/bp_settings.svh ====
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// x86 linear address width
`define BP_ADDR_W 32

// direct-mapped split of the fetch EIP
`define BP_INDEX_W 6           // EIP[5:0]
`define BP_TAG_W 26            // EIP[31:6]
`define BP_ENTRIES 64          // 2**BP_INDEX_W

// fetch block size, one sequential step
`define BP_FETCH_BYTES 16

// first fetch after reset
`define BP_RESET_EIP 32'h0000_1000

`endif

// ==== src/branch_target_buff.sv ====
`default_nettype none

`include "bp_settings.svh"

module branch_target_buff (
    input  logic                      clk,
    input  logic                      rst_n,
    input  bp_addr_pkg::eip_t         fetch_eip,     // lookup address
    input  bp_entry_pkg::btb_update_t update,        // from writeback
    input  logic                      flush,         // context switch
    output bp_entry_pkg::btb_lookup_t lookup
);

    // storage direct mapped on EIP[5:0]
    bp_entry_pkg::btb_entry_t btb_q [`BP_ENTRIES];

    // write side
    bp_addr_pkg::btb_idx_t    wr_idx;
    bp_entry_pkg::btb_entry_t wr_entry;

    // read side
    bp_addr_pkg::btb_idx_t    rd_idx;
    bp_addr_pkg::btb_tag_t    rd_tag;
    bp_entry_pkg::btb_entry_t rd_entry;
    logic                     tag_match;

    assign wr_idx = bp_addr_pkg::eip_idx(update.eip);

    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = bp_addr_pkg::eip_tag(update.eip);
        wr_entry.target = update.target;
        wr_entry.fip_e  = update.fip_e;
        wr_entry.fip_o  = update.fip_o;
    end

    // reset and flush clear the valid bits only
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                btb_q[i].valid <= 1'b0;
            end
        end else if (update.ld) begin
            btb_q[wr_idx] <= wr_entry;   // flush above beats a same-cycle write
        end
    end

    // lookup is purely combinational on the registered array
    // no bypass so a write in this cycle shows up next cycle
    assign rd_idx   = bp_addr_pkg::eip_idx(fetch_eip);
    assign rd_tag   = bp_addr_pkg::eip_tag(fetch_eip);
    assign rd_entry = btb_q[rd_idx];

    assign tag_match = (rd_entry.tag == rd_tag);

    always_comb begin
        lookup.hit    = rd_entry.valid && tag_match;   // valid bit keeps zero tags from aliasing
        lookup.target = rd_entry.target;               // payload read out regardless of hit
        lookup.fip_e  = rd_entry.fip_e;
        lookup.fip_o  = rd_entry.fip_o;
    end

endmodule

`default_nettype wire

// ==== src/fetch_packet_out.sv ====
`default_nettype none

module fetch_packet_out (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        issue,       // from fetch_pc_gen
    input  bp_addr_pkg::eip_t           fetch_eip,
    input  bp_entry_pkg::btb_lookup_t   lookup,
    output bp_entry_pkg::fetch_packet_t fetch
);

    bp_entry_pkg::fetch_packet_t pkt_q;

    // valid tracks issue one cycle later
    // payload only moves on a real fetch, it holds otherwise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_q.valid <= 1'b0;
        end else begin
            pkt_q.valid <= issue;
            if (issue) begin
                pkt_q.eip    <= fetch_eip;
                pkt_q.hit    <= lookup.hit;
                pkt_q.target <= lookup.target;
                pkt_q.fip_e  <= lookup.fip_e;
                pkt_q.fip_o  <= lookup.fip_o;
            end
        end
    end

    assign fetch = pkt_q;

endmodule

`default_nettype wire

// ==== src/fetch_pc_gen.sv ====
`default_nettype none

`include "bp_settings.svh"

module fetch_pc_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,
    input  bp_entry_pkg::redirect_t   redirect,
    input  bp_entry_pkg::btb_lookup_t lookup,
    output bp_addr_pkg::eip_t         fetch_eip,
    output logic                      issue
);

    bp_entry_pkg::pcg_state_t state_q;
    bp_entry_pkg::pcg_state_t state_d;
    bp_addr_pkg::eip_t        eip_q;
    bp_addr_pkg::eip_t        eip_d;
    bp_addr_pkg::eip_t        eip_seq;

    // next sequential block, wraps at 32 bits
    assign eip_seq = eip_q + bp_addr_pkg::eip_t'(`BP_FETCH_BYTES);

    always_comb begin
        state_d = state_q;
        eip_d   = eip_q;
        case (state_q)
            bp_entry_pkg::PCG_BOOT: begin
                state_d = bp_entry_pkg::PCG_FETCH;
                eip_d   = `BP_RESET_EIP;
            end
            bp_entry_pkg::PCG_FETCH: begin
                if (redirect.valid) begin
                    eip_d = redirect.eip;       // later stage wins over everything
                end else if (stall) begin
                    eip_d = eip_q;
                end else if (lookup.hit) begin
                    eip_d = lookup.target;      // every hit is predicted taken
                end else begin
                    eip_d = eip_seq;
                end
            end
            default: begin
                state_d = bp_entry_pkg::PCG_BOOT;
                eip_d   = `BP_RESET_EIP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= bp_entry_pkg::PCG_BOOT;
            eip_q   <= `BP_RESET_EIP;
        end else begin
            state_q <= state_d;
            eip_q   <= eip_d;
        end
    end

    assign fetch_eip = eip_q;

    // the current EIP is a real fetch only when it is neither held nor discarded
    assign issue = (state_q == bp_entry_pkg::PCG_FETCH) && !stall && !redirect.valid;

endmodule

`default_nettype wire

// ==== tests/bp_frontend_sva.sv ====
`default_nettype none

module bp_frontend_sva (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        stall,
    input logic                        flush,
    input bp_entry_pkg::redirect_t     redirect,
    input bp_entry_pkg::fetch_packet_t fetch
);

    int unsigned fail_count = 0;    // read by the testbench at the end of the run

    // the first slot after reset comes from PCG_BOOT, never a real fetch
    valid_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |=> !fetch.valid
    ) else begin
        fail_count++;
        $error("fetch packet valid in the cycle after reset");
    end

    // held or discarded EIPs must not produce a packet
    drop_on_stall_redirect: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall || redirect.valid) |=> !fetch.valid
    ) else begin
        fail_count++;
        $error("fetch packet valid after a stall or redirect cycle");
    end

    // packet registered one cycle after the flush edge looks at a cleared BTB
    no_hit_after_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> ##1 !(fetch.valid && fetch.hit)
    ) else begin
        fail_count++;
        $error("BTB hit reported after a flush");
    end

endmodule

bind bp_frontend_top bp_frontend_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .flush    (flush),
    .redirect (redirect),
    .fetch    (fetch)
);

`default_nettype wire

// ==== tests/bp_frontend_tb.sv ====
`default_nettype none

`include "bp_settings.svh"

module bp_frontend_tb;

    localparam int RESET_TIMEOUT = 10;      // clock cycles

    // one table row with its stimulus and the packet expected one clock later
    typedef struct packed {
        logic                        stall;
        logic                        flush;
        bp_entry_pkg::redirect_t     redirect;
        bp_entry_pkg::btb_update_t   update;
        logic                        chk;
        bp_entry_pkg::fetch_packet_t exp;
    } stim_row_t;

    logic                        clk;
    logic                        rst_n;
    logic                        stall;
    logic                        flush;
    bp_entry_pkg::redirect_t     redirect;
    bp_entry_pkg::btb_update_t   update;
    bp_entry_pkg::fetch_packet_t fetch;

    stim_row_t         rows[$];
    string             names[$];
    bp_addr_pkg::eip_t tgt[4];      // random branch targets
    bp_addr_pkg::fip_t fe[4];
    bp_addr_pkg::fip_t fo[4];
    int                wait_cycles;
    int                tests_run;
    int                tests_failed;

    tb_clock_gen clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bp_frontend_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .redirect (redirect),
        .update   (update),
        .fetch    (fetch)
    );

    function automatic bp_entry_pkg::redirect_t no_redirect();
        return '0;
    endfunction

    function automatic bp_entry_pkg::redirect_t redirect_to(bp_addr_pkg::eip_t eip);
        bp_entry_pkg::redirect_t r;
        r.valid = 1'b1;
        r.eip   = eip;
        return r;
    endfunction

    function automatic bp_entry_pkg::btb_update_t no_update();
        return '0;
    endfunction

    // writeback of branch at eip with payload set k
    function automatic bp_entry_pkg::btb_update_t update_at(bp_addr_pkg::eip_t eip, int k);
        bp_entry_pkg::btb_update_t u;
        u.ld     = 1'b1;
        u.eip    = eip;
        u.target = tgt[k];
        u.fip_e  = fe[k];
        u.fip_o  = fo[k];
        return u;
    endfunction

    function automatic bp_entry_pkg::fetch_packet_t dropped();
        return '0;
    endfunction

    function automatic bp_entry_pkg::fetch_packet_t miss_at(bp_addr_pkg::eip_t eip);
        bp_entry_pkg::fetch_packet_t p;
        p       = '0;
        p.valid = 1'b1;
        p.eip   = eip;
        return p;
    endfunction

    function automatic bp_entry_pkg::fetch_packet_t hit_at(bp_addr_pkg::eip_t eip, int k);
        bp_entry_pkg::fetch_packet_t p;
        p.valid  = 1'b1;
        p.eip    = eip;
        p.hit    = 1'b1;
        p.target = tgt[k];
        p.fip_e  = fe[k];
        p.fip_o  = fo[k];
        return p;
    endfunction

    // payload only matters on a valid packet and target fields only on a hit
    function automatic bit packet_matches(bp_entry_pkg::fetch_packet_t exp,
                                          bp_entry_pkg::fetch_packet_t act);
        if (act.valid !== exp.valid) return 1'b0;
        if (!exp.valid) return 1'b1;
        if (act.eip !== exp.eip || act.hit !== exp.hit) return 1'b0;
        if (exp.hit && (act.target !== exp.target || act.fip_e !== exp.fip_e ||
                        act.fip_o !== exp.fip_o)) return 1'b0;
        return 1'b1;
    endfunction

    task automatic add_row(string name, logic st, logic fl, bp_entry_pkg::redirect_t rd,
                           bp_entry_pkg::btb_update_t up, bp_entry_pkg::fetch_packet_t exp);
        stim_row_t row;
        row.stall    = st;
        row.flush    = fl;
        row.redirect = rd;
        row.update   = up;
        row.chk      = 1'b1;
        row.exp      = exp;
        rows.push_back(row);
        names.push_back(name);
    endtask

    // idle row whose packet is not compared
    task automatic add_idle_row(string name);
        stim_row_t row;
        row = '0;
        rows.push_back(row);
        names.push_back(name);
    endtask

    // targets keep bit 31 set so their tags never match the low test EIPs
    task automatic fill_random_payload();
        for (int k = 0; k < 4; k++) begin
            tgt[k] = $urandom | 32'h8000_0000;
            fe[k]  = $urandom;
            fo[k]  = $urandom;
        end
    endtask

    task automatic build_table();
        // reset vector and then misses stepping by 16
        add_row("reset_vector", 0, 0, no_redirect(), no_update(), miss_at(`BP_RESET_EIP));
        add_row("seq_step_1", 0, 0, no_redirect(), no_update(), miss_at(32'h1010));
        add_row("seq_step_2_wr_x", 0, 0, no_redirect(), update_at(32'h1040, 0),
                miss_at(32'h1020));                          // X is 0x1040 at index 0
        add_row("seq_step_3", 0, 0, no_redirect(), no_update(), miss_at(32'h1030));
        add_row("hit_x", 0, 0, no_redirect(), no_update(), hit_at(32'h1040, 0));
        add_row("follow_target_x", 0, 0, no_redirect(), no_update(), miss_at(tgt[0]));
        // same index as X with another tag and then a replacing write
        add_row("redirect_drop", 0, 0, redirect_to(32'h1000), no_update(), dropped());
        add_row("alias_miss_wr_y", 0, 0, no_redirect(), update_at(32'h1080, 1),
                miss_at(32'h1000));
        add_row("alias_seq_1", 0, 0, no_redirect(), no_update(), miss_at(32'h1010));
        add_row("alias_seq_2", 0, 0, no_redirect(), no_update(), miss_at(32'h1020));
        add_row("alias_seq_3", 0, 0, no_redirect(), no_update(), miss_at(32'h1030));
        add_row("replaced_miss", 0, 0, no_redirect(), no_update(), miss_at(32'h1040));
        add_row("redirect_to_y", 0, 0, redirect_to(32'h1080), no_update(), dropped());
        add_row("hit_y", 0, 0, no_redirect(), no_update(), hit_at(32'h1080, 1));
        add_row("follow_target_y", 0, 0, no_redirect(), no_update(), miss_at(tgt[1]));
        // flush beats the write in the same cycle
        add_row("flush_with_wr", 0, 1, redirect_to(32'h1080), update_at(32'h1090, 2),
                dropped());
        add_row("flushed_miss", 0, 0, no_redirect(), no_update(), miss_at(32'h1080));
        add_row("dropped_wr_miss", 0, 0, no_redirect(), no_update(), miss_at(32'h1090));
        // stall holds 0x10a0
        add_row("stall_1", 1, 0, no_redirect(), no_update(), dropped());
        add_row("stall_2", 1, 0, no_redirect(), no_update(), dropped());
        add_row("stall_resume", 0, 0, no_redirect(), no_update(), miss_at(32'h10a0));
        // write and lookup of the same line in one cycle without bypass
        add_row("same_cycle_wr", 0, 0, no_redirect(), update_at(32'h10b0, 3),
                miss_at(32'h10b0));
        add_row("redirect_back", 0, 0, redirect_to(32'h10b0), no_update(), dropped());
        add_row("late_hit", 0, 0, no_redirect(), no_update(), hit_at(32'h10b0, 3));
        add_row("follow_target_late", 0, 0, no_redirect(), no_update(), miss_at(tgt[3]));
        // idle rows let the bound properties see their last cycles
        add_idle_row("drain_1");
        add_idle_row("drain_2");
    endtask

    task automatic drive_row(stim_row_t row);
        stall    = row.stall;
        flush    = row.flush;
        redirect = row.redirect;
        update   = row.update;
    endtask

    task automatic check_row(string name, bp_entry_pkg::fetch_packet_t exp);
        bit ok;
        ok = packet_matches(exp, fetch);
        tests_run++;
        assert (ok) else begin
            tests_failed++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, fetch);
        end
        if (ok) $display("[PASS] %s", name);
    endtask

    initial begin
        stall        = 1'b0;
        flush        = 1'b0;
        redirect     = '0;
        update       = '0;
        tests_run    = 0;
        tests_failed = 0;
        wait_cycles  = 0;

        void'($urandom(32'h9832b5ad));
        fill_random_payload();
        build_table();

        while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end

        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("Something failed");
            $finish;
        end else begin
            @(negedge clk);
            for (int i = 0; i < rows.size(); i++) begin
                drive_row(rows[i]);
                @(negedge clk);                 // packet for this row is registered by now
                if (rows[i].chk) check_row(names[i], rows[i].exp);
            end

            $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                     tests_run, tests_run - tests_failed, tests_failed,
                     dut_i.u_sva.fail_count);
            if (tests_failed == 0 && dut_i.u_sva.fail_count == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // period 100
    end

    // two rising edges in reset, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
